// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module instDecoderTb -o simv
	-./obj_dir/simv | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: fieldStage.sv
`timescale 1ns/100ps

module fieldStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  rv32Pkg::word_t     instr,
    input  rv32Pkg::word_t     curPc,
    input  rv32Pkg::word_t     nxtPc,
    input  rv32Pkg::word_t     genImm,
    input  logic               fReady,
    output logic               inReady,
    output rv32Pkg::opcode_e   decOpcode,
    output logic               fValid,
    output rv32Pkg::opcode_e   opcode,
    output rv32Pkg::regIdx_t   rs1Idx,
    output rv32Pkg::regIdx_t   rs2Idx,
    output rv32Pkg::regIdx_t   rdIdx,
    output logic [2:0]         funct3,
    output logic               altBit,
    output rv32Pkg::word_t     imm,
    output rv32Pkg::word_t     pc,
    output rv32Pkg::word_t     nextPc
);

    logic started;
    logic accept;

    // classify the low bits, anything outside the nine groups is illegal
    always_comb begin
        case (instr[rv32Pkg::opcodeW-1:0])
            rv32Pkg::opLoad,
            rv32Pkg::opStore,
            rv32Pkg::opOpImm,
            rv32Pkg::opOp,
            rv32Pkg::opLui,
            rv32Pkg::opAuipc,
            rv32Pkg::opBranch,
            rv32Pkg::opJal,
            rv32Pkg::opJalr: begin
                decOpcode = rv32Pkg::opcode_e'(instr[rv32Pkg::opcodeW-1:0]);
            end
            default: begin
                decOpcode = rv32Pkg::opIllegal;
            end
        endcase
    end

    // held low through reset, then open while empty or draining
    assign inReady = started && (!fValid || fReady);
    assign accept = inValid && inReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            fValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (inReady) begin
                fValid <= inValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opcode <= decOpcode;
            rs1Idx <= instr[rv32Pkg::rs1Lsb +: rv32Pkg::regIdxW];
            rs2Idx <= instr[rv32Pkg::rs2Lsb +: rv32Pkg::regIdxW];
            rdIdx <= instr[rv32Pkg::rdLsb +: rv32Pkg::regIdxW];
            funct3 <= instr[rv32Pkg::funct3Lsb +: 3];
            altBit <= instr[rv32Pkg::altBit];
            imm <= genImm;
            pc <= curPc;
            nextPc <= nxtPc;
        end
    end

endmodule

// File: immGen.sv
`timescale 1ns/100ps

module immGen (
    input  rv32Pkg::word_t   instr,
    input  rv32Pkg::opcode_e opcode,
    output rv32Pkg::word_t   imm
);

    rv32Pkg::word_t immI;
    rv32Pkg::word_t immS;
    rv32Pkg::word_t immB;
    rv32Pkg::word_t immU;
    rv32Pkg::word_t immJ;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // branch and jump offsets are in half words
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        case (opcode)
            rv32Pkg::opLoad,
            rv32Pkg::opOpImm,
            rv32Pkg::opJalr: begin
                imm = immI;
            end
            rv32Pkg::opStore: begin
                imm = immS;
            end
            rv32Pkg::opBranch: begin
                imm = immB;
            end
            rv32Pkg::opLui,
            rv32Pkg::opAuipc: begin
                imm = immU;
            end
            rv32Pkg::opJal: begin
                imm = immJ;
            end
            // op has no immediate, illegal gets none either
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: instDecoder.sv
`timescale 1ns/100ps

module instDecoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  rv32Pkg::word_t     instr,
    input  rv32Pkg::word_t     curPc,
    input  rv32Pkg::word_t     nxtPc,
    output logic               inReady,
    input  logic               outReady,
    output logic               outValid,
    output uopPkg::unit_e      unit,
    output uopPkg::aluOp_e     aluOp,
    output uopPkg::brCond_e    brCond,
    output logic               memLoad,
    output uopPkg::ldSize_t    ldSize,
    output logic               ldUnsigned,
    output logic               needPc,
    output logic               rs1Use,
    output logic               rs2Use,
    output logic               rdWrite,
    output logic               immUse,
    output logic               illegal,
    output rv32Pkg::regIdx_t   uRs1,
    output rv32Pkg::regIdx_t   uRs2,
    output rv32Pkg::regIdx_t   uRd,
    output rv32Pkg::word_t     uImm,
    output rv32Pkg::word_t     uPc,
    output rv32Pkg::word_t     uNextPc
);

    rv32Pkg::opcode_e decOpcode;
    rv32Pkg::word_t   genImm;

    // field stage to uop stage link
    logic             fValid;
    logic             fReady;
    rv32Pkg::opcode_e opcode;
    rv32Pkg::regIdx_t rs1Idx;
    rv32Pkg::regIdx_t rs2Idx;
    rv32Pkg::regIdx_t rdIdx;
    logic [2:0]       funct3;
    logic             altBit;
    rv32Pkg::word_t   imm;
    rv32Pkg::word_t   pc;
    rv32Pkg::word_t   nextPc;

    immGen uImmGen (
        .instr  (instr),
        .opcode (decOpcode),
        .imm    (genImm)
    );

    fieldStage uFieldStage (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .instr     (instr),
        .curPc     (curPc),
        .nxtPc     (nxtPc),
        .genImm    (genImm),
        .fReady    (fReady),
        .inReady   (inReady),
        .decOpcode (decOpcode),
        .fValid    (fValid),
        .opcode    (opcode),
        .rs1Idx    (rs1Idx),
        .rs2Idx    (rs2Idx),
        .rdIdx     (rdIdx),
        .funct3    (funct3),
        .altBit    (altBit),
        .imm       (imm),
        .pc        (pc),
        .nextPc    (nextPc)
    );

    uopStage uUopStage (
        .clk        (clk),
        .rst        (rst),
        .fValid     (fValid),
        .opcode     (opcode),
        .rs1Idx     (rs1Idx),
        .rs2Idx     (rs2Idx),
        .rdIdx      (rdIdx),
        .funct3     (funct3),
        .altBit     (altBit),
        .imm        (imm),
        .pc         (pc),
        .nextPc     (nextPc),
        .outReady   (outReady),
        .fReady     (fReady),
        .outValid   (outValid),
        .unit       (unit),
        .aluOp      (aluOp),
        .brCond     (brCond),
        .memLoad    (memLoad),
        .ldSize     (ldSize),
        .ldUnsigned (ldUnsigned),
        .needPc     (needPc),
        .rs1Use     (rs1Use),
        .rs2Use     (rs2Use),
        .rdWrite    (rdWrite),
        .immUse     (immUse),
        .illegal    (illegal),
        .uRs1       (uRs1),
        .uRs2       (uRs2),
        .uRd        (uRd),
        .uImm       (uImm),
        .uPc        (uPc),
        .uNextPc    (uNextPc)
    );

endmodule

// File: instDecoderTb.sv
`timescale 1ns/100ps

module instDecoderTb;

    localparam int numTests = 5;

    logic clk;
    logic rst;
    logic inValid;
    rv32Pkg::word_t instr;
    rv32Pkg::word_t curPc;
    rv32Pkg::word_t nxtPc;
    logic inReady;
    logic outReady = 1'b1;
    logic outValid;
    uopPkg::unit_e unit;
    uopPkg::aluOp_e aluOp;
    uopPkg::brCond_e brCond;
    logic memLoad;
    uopPkg::ldSize_t ldSize;
    logic ldUnsigned;
    logic needPc;
    logic rs1Use;
    logic rs2Use;
    logic rdWrite;
    logic immUse;
    logic illegal;
    rv32Pkg::regIdx_t uRs1;
    rv32Pkg::regIdx_t uRs2;
    rv32Pkg::regIdx_t uRd;
    rv32Pkg::word_t uImm;
    rv32Pkg::word_t uPc;
    rv32Pkg::word_t uNextPc;

    logic randReady;
    int cycle = 0;
    rv32Pkg::word_t expInstr[$];
    rv32Pkg::word_t expPc[$];
    rv32Pkg::word_t expNextPc[$];
    int acceptCyc[$];
    int outCyc[$];

    tbClock clkGen (.clk(clk), .rst(rst));

    instDecoder i_dut (.*);

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkUnit(input string name, input uopPkg::unit_e got, input uopPkg::unit_e exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %s exp %s", $time, name, got.name(),
                               exp.name()));
        end
    endtask

    task automatic checkAlu(input string name, input uopPkg::aluOp_e got,
                            input uopPkg::aluOp_e exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %s exp %s", $time, name, got.name(),
                               exp.name()));
        end
    endtask

    task automatic checkBr(input string name, input uopPkg::brCond_e got,
                           input uopPkg::brCond_e exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %s exp %s", $time, name, got.name(),
                               exp.name()));
        end
    endtask

    task automatic checkWord(input string name, input rv32Pkg::word_t got,
                             input rv32Pkg::word_t exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp));
        end
    endtask

    task automatic checkIdx(input string name, input rv32Pkg::regIdx_t got,
                            input rv32Pkg::regIdx_t exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkSize(input string name, input uopPkg::ldSize_t got,
                             input uopPkg::ldSize_t exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp));
        end
    endtask

    function automatic uopPkg::aluOp_e aluFor(input logic [2:0] f3, input logic alt,
                                              input logic regOp);
        uopPkg::aluOp_e ops[8];
        ops = '{uopPkg::aluAdd, uopPkg::aluSll, uopPkg::aluSlt, uopPkg::aluSltu,
                uopPkg::aluXor, uopPkg::aluSrl, uopPkg::aluOr, uopPkg::aluAnd};
        if (f3 == 3'd0 && alt && regOp) begin
            return uopPkg::aluSub;
        end else if (f3 == 3'd5 && alt) begin
            return uopPkg::aluSra;
        end
        return ops[f3];
    endfunction

    // expected micro-op straight from the opcode group rules
    task automatic checkOutput(input rv32Pkg::word_t ins, input rv32Pkg::word_t p,
                               input rv32Pkg::word_t np);
        uopPkg::unit_e eUnit;
        uopPkg::aluOp_e eAlu;
        uopPkg::brCond_e eBr;
        uopPkg::brCond_e brTab[8];
        logic [3:0] use4;
        rv32Pkg::word_t eImm;
        rv32Pkg::word_t immI;
        logic [2:0] f3;
        logic eLoad;
        logic eUns;
        logic eNeedPc;
        logic eIll;
        uopPkg::ldSize_t eSize;
        brTab = '{uopPkg::brEq, uopPkg::brNe, uopPkg::brEq, uopPkg::brEq,
                  uopPkg::brLt, uopPkg::brGe, uopPkg::brLtu, uopPkg::brGeu};
        f3 = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        eUnit = uopPkg::unitNone;
        eAlu = uopPkg::aluAdd;
        eBr = uopPkg::brEq;
        eLoad = 1'b0;
        eSize = 2'd0;
        eUns = 1'b0;
        eNeedPc = 1'b0;
        eIll = 1'b0;
        eImm = '0;
        // rs1, rs2, rd, imm use flags
        use4 = 4'b0;
        case (ins[6:0])
            7'b0000011: begin
                eUnit = uopPkg::unitLs;
                eLoad = 1'b1;
                eSize = f3[1:0];
                eUns = f3[2];
                use4 = 4'b1011;
                eImm = immI;
            end
            7'b0100011: begin
                eUnit = uopPkg::unitLs;
                eSize = f3[1:0];
                use4 = 4'b1101;
                eImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            7'b0010011: begin
                eUnit = uopPkg::unitAlu;
                eAlu = aluFor(f3, ins[30], 1'b0);
                use4 = 4'b1011;
                eImm = immI;
            end
            7'b0110011: begin
                eUnit = uopPkg::unitAlu;
                eAlu = aluFor(f3, ins[30], 1'b1);
                use4 = 4'b1110;
            end
            7'b0110111, 7'b0010111: begin
                eUnit = uopPkg::unitLdPc;
                eNeedPc = (ins[6:0] == 7'b0010111);
                use4 = 4'b0011;
                eImm = {ins[31:12], 12'b0};
            end
            7'b1100011: begin
                eUnit = uopPkg::unitJmp;
                eBr = brTab[f3];
                use4 = 4'b1101;
                eImm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b1100111: begin
                eUnit = uopPkg::unitJmp;
                eBr = uopPkg::brJalr;
                use4 = 4'b1011;
                eImm = immI;
            end
            7'b1101111: begin
                eUnit = uopPkg::unitJmp;
                eBr = uopPkg::brJal;
                use4 = 4'b0011;
                eImm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: begin
                eIll = 1'b1;
            end
        endcase
        checkUnit("unit", unit, eUnit);
        checkAlu("aluOp", aluOp, eAlu);
        checkBr("brCond", brCond, eBr);
        checkFlag("memLoad", memLoad, eLoad);
        checkSize("ldSize", ldSize, eSize);
        checkFlag("ldUnsigned", ldUnsigned, eUns);
        checkFlag("needPc", needPc, eNeedPc);
        checkFlag("rs1Use", rs1Use, use4[3]);
        checkFlag("rs2Use", rs2Use, use4[2]);
        checkFlag("rdWrite", rdWrite, use4[1]);
        checkFlag("immUse", immUse, use4[0]);
        checkFlag("illegal", illegal, eIll);
        checkIdx("uRs1", uRs1, ins[19:15]);
        checkIdx("uRs2", uRs2, ins[24:20]);
        checkIdx("uRd", uRd, ins[11:7]);
        checkWord("uImm", uImm, eImm);
        checkWord("uPc", uPc, p);
        checkWord("uNextPc", uNextPc, np);
    endtask

    function automatic rv32Pkg::word_t makeInstr(input logic [6:0] op, input logic [2:0] f3,
                                                 input logic alt, input logic sign);
        rv32Pkg::word_t r;
        r = $urandom();
        return {sign, alt, r[29:15], f3, r[11:7], op};
    endfunction

    function automatic rv32Pkg::word_t randomInstr();
        logic [6:0] ops[9];
        logic [2:0] brF3[6];
        rv32Pkg::word_t r;
        logic [2:0] f3;
        ops = '{7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b0110111,
                7'b0010111, 7'b1100011, 7'b1101111, 7'b1100111};
        brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        r = $urandom();
        f3 = r[2:0];
        if (ops[r[7:4] % 9] == 7'b1100011) begin
            f3 = brF3[r[15:12] % 6];
        end
        return makeInstr(ops[r[7:4] % 9], f3, r[20], r[21]);
    endfunction

    task automatic pushInstr(input rv32Pkg::word_t ins);
        rv32Pkg::word_t p;
        rv32Pkg::word_t np;
        p = $urandom() & ~32'h3;
        np = $urandom() & ~32'h3;
        @(negedge clk);
        inValid = 1'b1;
        instr = ins;
        curPc = p;
        nxtPc = np;
        do @(posedge clk); while (!inReady);
        expInstr.push_back(ins);
        expPc.push_back(p);
        expNextPc.push_back(np);
        acceptCyc.push_back(cycle);
    endtask

    task automatic stopAndDrain();
        @(negedge clk);
        inValid = 1'b0;
        while (expInstr.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic testLoadStore();
        logic [2:0] ldF3[5];
        ldF3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        for (int s = 0; s < 2; s++) begin
            foreach (ldF3[i]) begin
                pushInstr(makeInstr(7'b0000011, ldF3[i], 1'b0, s[0]));
            end
            for (int f = 0; f < 3; f++) begin
                pushInstr(makeInstr(7'b0100011, f[2:0], 1'b0, s[0]));
            end
        end
        stopAndDrain();
    endtask

    task automatic testAlu();
        for (int f = 0; f < 8; f++) begin
            for (int a = 0; a < 2; a++) begin
                pushInstr(makeInstr(7'b0010011, f[2:0], a[0], f[0]));
                pushInstr(makeInstr(7'b0110011, f[2:0], a[0], f[1]));
            end
        end
        stopAndDrain();
    endtask

    task automatic testJumps();
        logic [2:0] brF3[6];
        brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int s = 0; s < 2; s++) begin
            foreach (brF3[i]) begin
                pushInstr(makeInstr(7'b1100011, brF3[i], 1'b1, s[0]));
            end
            pushInstr(makeInstr(7'b1101111, 3'd3, 1'b0, s[0]));
            pushInstr(makeInstr(7'b1100111, 3'd0, 1'b1, s[0]));
        end
        stopAndDrain();
    endtask

    task automatic testUpper();
        for (int s = 0; s < 2; s++) begin
            pushInstr(makeInstr(7'b0110111, 3'd2, 1'b0, s[0]));
            pushInstr(makeInstr(7'b0010111, 3'd5, 1'b1, s[0]));
        end
        // custom-0 space is not decoded
        pushInstr(makeInstr(7'b0001011, 3'd0, 1'b0, 1'b0));
        stopAndDrain();
    endtask

    task automatic testStream();
        randReady = 1'b1;
        repeat (10) pushInstr(randomInstr());
        stopAndDrain();
        randReady = 1'b0;
        @(negedge clk);
        acceptCyc.delete();
        outCyc.delete();
        repeat (6) pushInstr(randomInstr());
        stopAndDrain();
        for (int i = 0; i < 6; i++) begin
            if (acceptCyc[i] != acceptCyc[0] + i) begin
                abortRun("input not accepted every cycle with the sink ready");
            end else if (outCyc[i] != acceptCyc[0] + 2 + i) begin
                abortRun("result not delivered two cycles after accept");
            end
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin
        rv32Pkg::word_t r;
        r = $urandom();
        outReady = randReady ? r[0] : 1'b1;
    end

    // results leave in acceptance order, each exactly once
    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            if (expInstr.size() == 0) begin
                abortRun("result delivered with no instruction pending");
            end else begin
                checkOutput(expInstr.pop_front(), expPc.pop_front(), expNextPc.pop_front());
                outCyc.push_back(cycle);
            end
        end
    end

    initial begin
        repeat (numTests * 200 + 10) @(posedge clk);
        abortRun("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(82139));
        inValid = 1'b0;
        instr = '0;
        curPc = '0;
        nxtPc = '0;
        randReady = 1'b0;
        wait (!rst);
        @(negedge clk);
        testLoadStore();
        testAlu();
        testJumps();
        testUpper();
        testStream();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: instDecoder_properties.sv
`timescale 1ns/100ps

module instDecoderProperties (
    input logic             clk,
    input logic             rst,
    input logic             outValid,
    input logic             outReady,
    input uopPkg::unit_e    unit,
    input uopPkg::aluOp_e   aluOp,
    input uopPkg::brCond_e  brCond,
    input logic             illegal,
    input rv32Pkg::regIdx_t uRd,
    input rv32Pkg::word_t   uImm,
    input rv32Pkg::word_t   uPc
);

    // a stalled result must not move
    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(unit) && $stable(aluOp)
            && $stable(brCond) && $stable(uRd) && $stable(uImm) && $stable(uPc))
        else $error("output changed while stalled");

    emptyAfterReset: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high after reset");

    illegalHasNoUnit: assert property (@(posedge clk) disable iff (rst)
        outValid && illegal |-> unit == uopPkg::unitNone)
        else $error("illegal micro-op selects a unit");

endmodule

bind instDecoder instDecoderProperties props (.*);

// File: rv32Pkg.sv
package rv32Pkg;

    localparam int xlen = 32;
    localparam int regIdxW = 5;
    localparam int opcodeW = 7;

    typedef logic [xlen-1:0] word_t;
    typedef logic [regIdxW-1:0] regIdx_t;

    // instruction field positions
    localparam int rdLsb = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb = 15;
    localparam int rs2Lsb = 20;
    localparam int altBit = 30;

    // base opcodes, all-zero is not a valid RV32I code
    typedef enum logic [opcodeW-1:0] {
        opIllegal = 7'b0000000,
        opLoad    = 7'b0000011,
        opStore   = 7'b0100011,
        opOpImm   = 7'b0010011,
        opOp      = 7'b0110011,
        opLui     = 7'b0110111,
        opAuipc   = 7'b0010111,
        opBranch  = 7'b1100011,
        opJal     = 7'b1101111,
        opJalr    = 7'b1100111
    } opcode_e;

    // alu funct3
    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Sr = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

endpackage

// File: tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset held for four rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: uopPkg.sv
package uopPkg;

    // execution unit that takes the micro-op
    typedef enum logic [2:0] {
        unitNone = 3'd0,
        unitLs   = 3'd1,
        unitAlu  = 3'd2,
        unitJmp  = 3'd3,
        unitLdPc = 3'd4
    } unit_e;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluXor  = 4'd2,
        aluOr   = 4'd3,
        aluAnd  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluSll  = 4'd7,
        aluSrl  = 4'd8,
        aluSra  = 4'd9
    } aluOp_e;

    // jal and jalr share the jump unit with the branches
    typedef enum logic [2:0] {
        brEq   = 3'd0,
        brNe   = 3'd1,
        brLt   = 3'd2,
        brGe   = 3'd3,
        brLtu  = 3'd4,
        brGeu  = 3'd5,
        brJal  = 3'd6,
        brJalr = 3'd7
    } brCond_e;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] ldSize_t;

endpackage

// File: uopStage.sv
`timescale 1ns/100ps

module uopStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               fValid,
    input  rv32Pkg::opcode_e   opcode,
    input  rv32Pkg::regIdx_t   rs1Idx,
    input  rv32Pkg::regIdx_t   rs2Idx,
    input  rv32Pkg::regIdx_t   rdIdx,
    input  logic [2:0]         funct3,
    input  logic               altBit,
    input  rv32Pkg::word_t     imm,
    input  rv32Pkg::word_t     pc,
    input  rv32Pkg::word_t     nextPc,
    input  logic               outReady,
    output logic               fReady,
    output logic               outValid,
    output uopPkg::unit_e      unit,
    output uopPkg::aluOp_e     aluOp,
    output uopPkg::brCond_e    brCond,
    output logic               memLoad,
    output uopPkg::ldSize_t    ldSize,
    output logic               ldUnsigned,
    output logic               needPc,
    output logic               rs1Use,
    output logic               rs2Use,
    output logic               rdWrite,
    output logic               immUse,
    output logic               illegal,
    output rv32Pkg::regIdx_t   uRs1,
    output rv32Pkg::regIdx_t   uRs2,
    output rv32Pkg::regIdx_t   uRd,
    output rv32Pkg::word_t     uImm,
    output rv32Pkg::word_t     uPc,
    output rv32Pkg::word_t     uNextPc
);

    uopPkg::unit_e   nUnit;
    uopPkg::aluOp_e  nAluOp;
    uopPkg::brCond_e nBrCond;
    logic [9:0]      nFlags;

    // bit 30 selects sub only for register ops, sra for both
    function automatic uopPkg::aluOp_e aluSel(input logic [2:0] f3, input logic alt,
                                              input logic isReg);
        case (f3)
            rv32Pkg::f3Add:  aluSel = (isReg && alt) ? uopPkg::aluSub : uopPkg::aluAdd;
            rv32Pkg::f3Sll:  aluSel = uopPkg::aluSll;
            rv32Pkg::f3Slt:  aluSel = uopPkg::aluSlt;
            rv32Pkg::f3Sltu: aluSel = uopPkg::aluSltu;
            rv32Pkg::f3Xor:  aluSel = uopPkg::aluXor;
            rv32Pkg::f3Sr:   aluSel = alt ? uopPkg::aluSra : uopPkg::aluSrl;
            rv32Pkg::f3Or:   aluSel = uopPkg::aluOr;
            default:         aluSel = uopPkg::aluAnd;
        endcase
    endfunction

    function automatic uopPkg::brCond_e brSel(input logic [2:0] f3);
        case (f3)
            rv32Pkg::f3Bne:  brSel = uopPkg::brNe;
            rv32Pkg::f3Blt:  brSel = uopPkg::brLt;
            rv32Pkg::f3Bge:  brSel = uopPkg::brGe;
            rv32Pkg::f3Bltu: brSel = uopPkg::brLtu;
            rv32Pkg::f3Bgeu: brSel = uopPkg::brGeu;
            // beq and the two reserved codes
            default:         brSel = uopPkg::brEq;
        endcase
    endfunction

    // flag order memLoad, ldSize, ldUnsigned, needPc, rs1, rs2, rd, imm, illegal
    always_comb begin
        nUnit = uopPkg::unitNone;
        nAluOp = uopPkg::aluAdd;
        nBrCond = uopPkg::brEq;
        nFlags = '0;
        case (opcode)
            rv32Pkg::opLoad: begin
                nUnit = uopPkg::unitLs;
                nFlags = {1'b1, funct3[1:0], funct3[2], 1'b0, 4'b1011, 1'b0};
            end
            rv32Pkg::opStore: begin
                nUnit = uopPkg::unitLs;
                nFlags = {1'b0, funct3[1:0], 1'b0, 1'b0, 4'b1101, 1'b0};
            end
            rv32Pkg::opOpImm: begin
                nUnit = uopPkg::unitAlu;
                nAluOp = aluSel(funct3, altBit, 1'b0);
                nFlags = {5'b0, 4'b1011, 1'b0};
            end
            rv32Pkg::opOp: begin
                nUnit = uopPkg::unitAlu;
                nAluOp = aluSel(funct3, altBit, 1'b1);
                nFlags = {5'b0, 4'b1110, 1'b0};
            end
            rv32Pkg::opLui,
            rv32Pkg::opAuipc: begin
                nUnit = uopPkg::unitLdPc;
                nFlags = {4'b0, opcode == rv32Pkg::opAuipc, 4'b0011, 1'b0};
            end
            rv32Pkg::opBranch: begin
                nUnit = uopPkg::unitJmp;
                nBrCond = brSel(funct3);
                nFlags = {5'b0, 4'b1101, 1'b0};
            end
            rv32Pkg::opJalr: begin
                nUnit = uopPkg::unitJmp;
                nBrCond = uopPkg::brJalr;
                nFlags = {5'b0, 4'b1011, 1'b0};
            end
            rv32Pkg::opJal: begin
                nUnit = uopPkg::unitJmp;
                nBrCond = uopPkg::brJal;
                nFlags = {5'b0, 4'b0011, 1'b0};
            end
            default: begin
                nFlags = {9'b0, 1'b1};
            end
        endcase
    end

    assign fReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (fReady) begin
            outValid <= fValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fValid && fReady) begin
            unit <= nUnit;
            aluOp <= nAluOp;
            brCond <= nBrCond;
            {memLoad, ldSize, ldUnsigned, needPc} <= nFlags[9:5];
            {rs1Use, rs2Use, rdWrite, immUse, illegal} <= nFlags[4:0];
            uRs1 <= rs1Idx;
            uRs2 <= rs2Idx;
            uRd <= rdIdx;
            uImm <= imm;
            uPc <= pc;
            uNextPc <= nextPc;
        end
    end

endmodule

// File: vlog.f
rv32Pkg.sv
uopPkg.sv
immGen.sv
fieldStage.sv
uopStage.sv
instDecoder.sv
tbClock.sv
instDecoder_properties.sv
instDecoderTb.sv
